// ==== hdl/axi_pkg.sv ====
package axi_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // response codes
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // every transfer is a single word beat
  localparam logic [2:0] SIZE_WORD  = 3'd2;
  localparam logic [1:0] BURST_INCR = 2'd1;

  // shared by ar and aw
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [3:0]        id;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } addr_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
    logic                last;
  } w_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic [3:0]        id;
    logic              last;
  } r_t;

  typedef struct packed {
    logic [1:0] resp;
    logic [3:0] id;
  } b_t;

endpackage

// ==== hdl/soc_pkg.sv ====
package soc_pkg;

  // core-local timer region
  localparam logic [axi_pkg::ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [axi_pkg::ADDR_W-1:0] CLINT_SPAN = 32'h0001_0000;

  // mtime word offsets inside the region
  localparam logic [axi_pkg::ADDR_W-1:0] MTIME_LO_OFS = 32'h0000_0000;
  localparam logic [axi_pkg::ADDR_W-1:0] MTIME_HI_OFS = 32'h0000_0004;

  // arid values seen on the external bus
  localparam logic [3:0] FETCH_ID = 4'd0;
  localparam logic [3:0] LSU_ID   = 4'd1;

endpackage

// ==== hdl/chan_slice.sv ====
`timescale 1ns/1ps

module chan_slice #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     main_valid;
  logic     skid_valid;
  payload_t main_data;
  payload_t skid_data;
  logic     main_load;
  logic     in_fire;

  // input stalls only once the skid entry is taken too
  assign in_ready  = ~skid_valid;
  assign in_fire   = in_valid & in_ready;
  assign main_load = out_ready | ~main_valid;
  assign out_valid = main_valid;
  assign out_data  = main_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      main_valid <= skid_valid | in_valid;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    // skid entry drains first to keep order
    if (main_load) begin
      main_data <= skid_valid ? skid_data : in_data;
    end
    if (~main_load & in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

// ==== hdl/read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter (
  input  logic               clock,
  input  logic               reset,
  input  logic               fetch_ar_valid,
  output logic               fetch_ar_ready,
  input  axi_pkg::addr_req_t fetch_ar,
  output logic               fetch_r_valid,
  input  logic               fetch_r_ready,
  output axi_pkg::r_t        fetch_r,
  input  logic               lsu_ar_valid,
  output logic               lsu_ar_ready,
  input  axi_pkg::addr_req_t lsu_ar,
  output logic               lsu_r_valid,
  input  logic               lsu_r_ready,
  output axi_pkg::r_t        lsu_r,
  output logic               rd_ar_valid,
  input  logic               rd_ar_ready,
  output axi_pkg::addr_req_t rd_ar,
  input  logic               rd_r_valid,
  output logic               rd_r_ready,
  input  axi_pkg::r_t        rd_r
);

  typedef enum logic [1:0] {
    OWN_IDLE,
    OWN_FETCH,
    OWN_LSU
  } owner_t;

  owner_t owner;
  logic   ar_sent;
  logic   pick_lsu;
  logic   rd_ar_fire;
  logic   rd_r_fire;

  // load/store wins a tie and an owned slot sticks to its requester
  assign pick_lsu    = (owner == OWN_IDLE) ? lsu_ar_valid : (owner == OWN_LSU);
  assign rd_ar_valid = ~ar_sent & (pick_lsu ? lsu_ar_valid : fetch_ar_valid);
  assign rd_ar_fire  = rd_ar_valid & rd_ar_ready;
  assign rd_r_fire   = rd_r_valid & rd_r_ready;

  // requester ready only answers its own live request
  assign fetch_ar_ready = rd_ar_ready & ~ar_sent & ~pick_lsu & fetch_ar_valid;
  assign lsu_ar_ready   = rd_ar_ready & ~ar_sent & pick_lsu & lsu_ar_valid;

  always_comb begin
    rd_ar       = pick_lsu ? lsu_ar : fetch_ar;
    rd_ar.id    = pick_lsu ? soc_pkg::LSU_ID : soc_pkg::FETCH_ID;
    rd_ar.len   = 8'd0;
    rd_ar.size  = axi_pkg::SIZE_WORD;
    rd_ar.burst = axi_pkg::BURST_INCR;
  end

  // response goes to the owner only
  assign fetch_r_valid = rd_r_valid & (owner == OWN_FETCH);
  assign lsu_r_valid   = rd_r_valid & (owner == OWN_LSU);
  assign fetch_r       = rd_r;
  assign lsu_r         = rd_r;

  always_comb begin
    case (owner)
      OWN_FETCH: rd_r_ready = fetch_r_ready;
      OWN_LSU:   rd_r_ready = lsu_r_ready;
      default:   rd_r_ready = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      owner   <= OWN_IDLE;
      ar_sent <= 1'b0;
    end else if (rd_r_fire) begin
      owner   <= OWN_IDLE;
      ar_sent <= 1'b0;
    end else begin
      if (owner == OWN_IDLE && rd_ar_valid) begin
        owner <= pick_lsu ? OWN_LSU : OWN_FETCH;
      end
      if (rd_ar_fire) begin
        ar_sent <= 1'b1;
      end
    end
  end

endmodule

// ==== hdl/addr_router.sv ====
`timescale 1ns/1ps

module addr_router (
  input  logic               clock,
  input  logic               reset,
  input  logic               rd_ar_valid,
  output logic               rd_ar_ready,
  input  axi_pkg::addr_req_t rd_ar,
  output logic               rd_r_valid,
  input  logic               rd_r_ready,
  output axi_pkg::r_t        rd_r,
  input  logic               lsu_aw_valid,
  output logic               lsu_aw_ready,
  input  axi_pkg::addr_req_t lsu_aw,
  input  logic               lsu_w_valid,
  output logic               lsu_w_ready,
  input  axi_pkg::w_t        lsu_w,
  output logic               lsu_b_valid,
  input  logic               lsu_b_ready,
  output axi_pkg::b_t        lsu_b,
  output logic               clint_ar_valid,
  input  logic               clint_ar_ready,
  output axi_pkg::addr_req_t clint_ar,
  input  logic               clint_r_valid,
  output logic               clint_r_ready,
  input  axi_pkg::r_t        clint_r,
  output logic               clint_aw_valid,
  input  logic               clint_aw_ready,
  output axi_pkg::addr_req_t clint_aw,
  output logic               clint_w_valid,
  input  logic               clint_w_ready,
  output axi_pkg::w_t        clint_w,
  input  logic               clint_b_valid,
  output logic               clint_b_ready,
  input  axi_pkg::b_t        clint_b,
  output logic               ext_ar_valid,
  input  logic               ext_ar_ready,
  output axi_pkg::addr_req_t ext_ar,
  input  logic               ext_r_valid,
  output logic               ext_r_ready,
  input  axi_pkg::r_t        ext_r,
  output logic               ext_aw_valid,
  input  logic               ext_aw_ready,
  output axi_pkg::addr_req_t ext_aw,
  output logic               ext_w_valid,
  input  logic               ext_w_ready,
  output axi_pkg::w_t        ext_w,
  input  logic               ext_b_valid,
  output logic               ext_b_ready,
  input  axi_pkg::b_t        ext_b
);

  logic rd_clint;
  logic rd_fire;
  logic rd_pend;
  logic rd_pend_clint;
  logic wr_clint;
  logic wr_req;
  logic wr_accept;
  logic wr_pend;
  logic wr_pend_clint;
  logic aw_done;
  logic w_done;
  logic aw_out_valid;
  logic w_out_valid;
  logic aw_take;
  logic w_take;

  function automatic logic in_clint(input logic [axi_pkg::ADDR_W-1:0] addr);
    return (addr >= soc_pkg::CLINT_BASE) &&
           ((addr - soc_pkg::CLINT_BASE) < soc_pkg::CLINT_SPAN);
  endfunction

  // read side, one request in flight
  assign rd_clint       = in_clint(rd_ar.addr);
  assign clint_ar_valid = rd_ar_valid & ~rd_pend & rd_clint;
  assign ext_ar_valid   = rd_ar_valid & ~rd_pend & ~rd_clint;
  assign rd_ar_ready    = ~rd_pend & (rd_clint ? clint_ar_ready : ext_ar_ready);
  assign clint_ar       = rd_ar;
  assign ext_ar         = rd_ar;
  assign rd_fire        = rd_ar_valid & rd_ar_ready;

  assign rd_r_valid    = rd_pend & (rd_pend_clint ? clint_r_valid : ext_r_valid);
  assign rd_r          = rd_pend_clint ? clint_r : ext_r;
  assign clint_r_ready = rd_pend & rd_pend_clint & rd_r_ready;
  assign ext_r_ready   = rd_pend & ~rd_pend_clint & rd_r_ready;

  // write side, aw and w held until both halves are taken downstream
  assign wr_clint       = in_clint(lsu_aw.addr);
  assign wr_req         = lsu_aw_valid & lsu_w_valid & ~wr_pend;
  assign aw_out_valid   = wr_req & ~aw_done;
  assign w_out_valid    = wr_req & ~w_done;
  assign clint_aw_valid = aw_out_valid & wr_clint;
  assign ext_aw_valid   = aw_out_valid & ~wr_clint;
  assign clint_w_valid  = w_out_valid & wr_clint;
  assign ext_w_valid    = w_out_valid & ~wr_clint;
  assign clint_aw       = lsu_aw;
  assign ext_aw         = lsu_aw;
  assign clint_w        = lsu_w;
  assign ext_w          = lsu_w;

  assign aw_take      = aw_out_valid & (wr_clint ? clint_aw_ready : ext_aw_ready);
  assign w_take       = w_out_valid & (wr_clint ? clint_w_ready : ext_w_ready);
  assign wr_accept    = wr_req & (aw_done | aw_take) & (w_done | w_take);
  assign lsu_aw_ready = wr_accept;
  assign lsu_w_ready  = wr_accept;

  assign lsu_b_valid   = wr_pend & (wr_pend_clint ? clint_b_valid : ext_b_valid);
  assign lsu_b         = wr_pend_clint ? clint_b : ext_b;
  assign clint_b_ready = wr_pend & wr_pend_clint & lsu_b_ready;
  assign ext_b_ready   = wr_pend & ~wr_pend_clint & lsu_b_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_pend       <= 1'b0;
      rd_pend_clint <= 1'b0;
      wr_pend       <= 1'b0;
      wr_pend_clint <= 1'b0;
      aw_done       <= 1'b0;
      w_done        <= 1'b0;
    end else begin
      if (rd_fire) begin
        rd_pend       <= 1'b1;
        rd_pend_clint <= rd_clint;
      end else if (rd_r_valid & rd_r_ready) begin
        rd_pend <= 1'b0;
      end
      if (wr_accept) begin
        wr_pend       <= 1'b1;
        wr_pend_clint <= wr_clint;
        aw_done       <= 1'b0;
        w_done        <= 1'b0;
      end else begin
        if (aw_take) begin
          aw_done <= 1'b1;
        end
        if (w_take) begin
          w_done <= 1'b1;
        end
        if (lsu_b_valid & lsu_b_ready) begin
          wr_pend <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== hdl/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer (
  input  logic               clock,
  input  logic               reset,
  input  logic               ar_valid,
  output logic               ar_ready,
  input  axi_pkg::addr_req_t ar,
  output logic               r_valid,
  input  logic               r_ready,
  output axi_pkg::r_t        r,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  axi_pkg::addr_req_t aw,
  input  logic               w_valid,
  output logic               w_ready,
  input  axi_pkg::w_t        w,
  output logic               b_valid,
  input  logic               b_ready,
  output axi_pkg::b_t        b
);

  logic [63:0]                mtime;
  logic [axi_pkg::ADDR_W-1:0] ofs;
  logic [axi_pkg::DATA_W-1:0] rd_word;
  logic                       rd_fire;
  logic                       wr_fire;

  assign ofs = ar.addr - soc_pkg::CLINT_BASE;

  always_comb begin
    if (ofs == soc_pkg::MTIME_LO_OFS) begin
      rd_word = mtime[31:0];
    end else if (ofs == soc_pkg::MTIME_HI_OFS) begin
      rd_word = mtime[63:32];
    end else begin
      rd_word = '0;
    end
  end

  assign ar_ready = ~r_valid;
  assign rd_fire  = ar_valid & ar_ready;
  // aw and w are taken together, mtime is read-only
  assign aw_ready = ~b_valid & w_valid;
  assign w_ready  = ~b_valid & aw_valid & w.last;
  assign wr_fire  = aw_valid & w_valid & w.last & ~b_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime   <= 64'd0;
      r_valid <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      if (rd_fire) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
      if (wr_fire) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_fire) begin
      r.data <= rd_word;
      r.resp <= axi_pkg::RESP_OKAY;
      r.id   <= ar.id;
      r.last <= 1'b1;
    end
    if (wr_fire) begin
      b.resp <= axi_pkg::RESP_SLVERR;
      b.id   <= aw.id;
    end
  end

endmodule

// ==== hdl/mem_fabric_top.sv ====
`timescale 1ns/1ps

module mem_fabric_top (
  input  logic               clock,
  input  logic               reset,
  input  logic               fetch_ar_valid,
  output logic               fetch_ar_ready,
  input  axi_pkg::addr_req_t fetch_ar,
  output logic               fetch_r_valid,
  input  logic               fetch_r_ready,
  output axi_pkg::r_t        fetch_r,
  input  logic               lsu_ar_valid,
  output logic               lsu_ar_ready,
  input  axi_pkg::addr_req_t lsu_ar,
  output logic               lsu_r_valid,
  input  logic               lsu_r_ready,
  output axi_pkg::r_t        lsu_r,
  input  logic               lsu_aw_valid,
  output logic               lsu_aw_ready,
  input  axi_pkg::addr_req_t lsu_aw,
  input  logic               lsu_w_valid,
  output logic               lsu_w_ready,
  input  axi_pkg::w_t        lsu_w,
  output logic               lsu_b_valid,
  input  logic               lsu_b_ready,
  output axi_pkg::b_t        lsu_b,
  output logic               ext_ar_valid,
  input  logic               ext_ar_ready,
  output axi_pkg::addr_req_t ext_ar,
  input  logic               ext_r_valid,
  output logic               ext_r_ready,
  input  axi_pkg::r_t        ext_r,
  output logic               ext_aw_valid,
  input  logic               ext_aw_ready,
  output axi_pkg::addr_req_t ext_aw,
  output logic               ext_w_valid,
  input  logic               ext_w_ready,
  output axi_pkg::w_t        ext_w,
  input  logic               ext_b_valid,
  output logic               ext_b_ready,
  input  axi_pkg::b_t        ext_b
);

  // merged read between arbiter and router
  logic               rd_ar_valid, rd_ar_ready;
  axi_pkg::addr_req_t rd_ar;
  logic               rd_r_valid, rd_r_ready;
  axi_pkg::r_t        rd_r;

  logic               clint_ar_valid, clint_ar_ready;
  axi_pkg::addr_req_t clint_ar;
  logic               clint_r_valid, clint_r_ready;
  axi_pkg::r_t        clint_r;
  logic               clint_aw_valid, clint_aw_ready;
  axi_pkg::addr_req_t clint_aw;
  logic               clint_w_valid, clint_w_ready;
  axi_pkg::w_t        clint_w;
  logic               clint_b_valid, clint_b_ready;
  axi_pkg::b_t        clint_b;

  // router side of the external request slices
  logic               rt_ar_valid, rt_ar_ready;
  axi_pkg::addr_req_t rt_ar;
  logic               rt_aw_valid, rt_aw_ready;
  axi_pkg::addr_req_t rt_aw;
  logic               rt_w_valid, rt_w_ready;
  axi_pkg::w_t        rt_w;

  read_arbiter u_arb (.*);

  addr_router u_router (
    .ext_ar_valid(rt_ar_valid), .ext_ar_ready(rt_ar_ready), .ext_ar(rt_ar),
    .ext_aw_valid(rt_aw_valid), .ext_aw_ready(rt_aw_ready), .ext_aw(rt_aw),
    .ext_w_valid (rt_w_valid),  .ext_w_ready (rt_w_ready),  .ext_w (rt_w),
    .*
  );

  clint_timer u_clint (
    .clock   (clock),
    .reset   (reset),
    .ar_valid(clint_ar_valid), .ar_ready(clint_ar_ready), .ar(clint_ar),
    .r_valid (clint_r_valid),  .r_ready (clint_r_ready),  .r (clint_r),
    .aw_valid(clint_aw_valid), .aw_ready(clint_aw_ready), .aw(clint_aw),
    .w_valid (clint_w_valid),  .w_ready (clint_w_ready),  .w (clint_w),
    .b_valid (clint_b_valid),  .b_ready (clint_b_ready),  .b (clint_b)
  );

  chan_slice #(.payload_t(axi_pkg::addr_req_t)) u_ar_slice (
    .clock    (clock),
    .reset    (reset),
    .in_valid (rt_ar_valid),  .in_ready (rt_ar_ready),  .in_data (rt_ar),
    .out_valid(ext_ar_valid), .out_ready(ext_ar_ready), .out_data(ext_ar)
  );

  chan_slice #(.payload_t(axi_pkg::addr_req_t)) u_aw_slice (
    .clock    (clock),
    .reset    (reset),
    .in_valid (rt_aw_valid),  .in_ready (rt_aw_ready),  .in_data (rt_aw),
    .out_valid(ext_aw_valid), .out_ready(ext_aw_ready), .out_data(ext_aw)
  );

  chan_slice #(.payload_t(axi_pkg::w_t)) u_w_slice (
    .clock    (clock),
    .reset    (reset),
    .in_valid (rt_w_valid),  .in_ready (rt_w_ready),  .in_data (rt_w),
    .out_valid(ext_w_valid), .out_ready(ext_w_ready), .out_data(ext_w)
  );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // held for ten rising edges
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

// ==== verif/fabric_chk.sv ====
`timescale 1ns/1ps

module fabric_chk (
  input logic               clock,
  input logic               reset,
  input logic               rd_ar_valid,
  input logic               rd_ar_ready,
  input logic               rd_r_valid,
  input logic               rd_r_ready,
  input logic               fetch_ar_valid,
  input logic               fetch_ar_ready,
  input logic               lsu_ar_valid,
  input logic               lsu_ar_ready,
  input logic               ext_ar_valid,
  input logic               ext_ar_ready,
  input axi_pkg::addr_req_t ext_ar
);

  logic rd_busy;

  // one read slot between arbiter grant and its response
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_busy <= 1'b0;
    end else if (rd_r_valid & rd_r_ready) begin
      rd_busy <= 1'b0;
    end else if (rd_ar_valid & rd_ar_ready) begin
      rd_busy <= 1'b1;
    end
  end

  no_grant_while_busy: assert property (@(posedge clock) disable iff (reset)
    rd_busy |-> !(rd_ar_valid && rd_ar_ready))
    else $error("arbiter granted a read while one was outstanding");

  no_requester_grant_while_busy: assert property (@(posedge clock) disable iff (reset)
    rd_busy |-> !(fetch_ar_valid && fetch_ar_ready) && !(lsu_ar_valid && lsu_ar_ready))
    else $error("requester read accepted while the read slot was taken");

  ext_ar_held: assert property (@(posedge clock) disable iff (reset)
    (ext_ar_valid && !ext_ar_ready) |=> (ext_ar_valid && $stable(ext_ar)))
    else $error("external arvalid or its payload changed before the transfer");

endmodule

bind mem_fabric_top fabric_chk u_chk (
  .clock         (clock),
  .reset         (reset),
  .rd_ar_valid   (rd_ar_valid),
  .rd_ar_ready   (rd_ar_ready),
  .rd_r_valid    (rd_r_valid),
  .rd_r_ready    (rd_r_ready),
  .fetch_ar_valid(fetch_ar_valid),
  .fetch_ar_ready(fetch_ar_ready),
  .lsu_ar_valid  (lsu_ar_valid),
  .lsu_ar_ready  (lsu_ar_ready),
  .ext_ar_valid  (ext_ar_valid),
  .ext_ar_ready  (ext_ar_ready),
  .ext_ar        (ext_ar)
);

// ==== verif/fabric_tb.sv ====
`timescale 1ns/1ps

module fabric_tb;

  localparam int N_EXT_READS  = 8;
  localparam int N_WRITES     = 8;
  localparam int N_PAIRS      = 8;
  localparam int N_TIMER      = 4;
  localparam int N_TXN        = N_EXT_READS + 2 * N_WRITES + 2 * N_PAIRS + N_TIMER + 3;
  // worst case for one transaction including ready waits and response delay
  localparam int WORST_CYCLES = 64;
  localparam int CLK_NS       = 8;

  logic               clock;
  logic               reset;
  logic               fetch_ar_valid, fetch_ar_ready;
  axi_pkg::addr_req_t fetch_ar;
  logic               fetch_r_valid, fetch_r_ready;
  axi_pkg::r_t        fetch_r;
  logic               lsu_ar_valid, lsu_ar_ready;
  axi_pkg::addr_req_t lsu_ar;
  logic               lsu_r_valid, lsu_r_ready;
  axi_pkg::r_t        lsu_r;
  logic               lsu_aw_valid, lsu_aw_ready;
  axi_pkg::addr_req_t lsu_aw;
  logic               lsu_w_valid, lsu_w_ready;
  axi_pkg::w_t        lsu_w;
  logic               lsu_b_valid, lsu_b_ready;
  axi_pkg::b_t        lsu_b;
  logic               ext_ar_valid, ext_ar_ready;
  axi_pkg::addr_req_t ext_ar;
  logic               ext_r_valid, ext_r_ready;
  axi_pkg::r_t        ext_r;
  logic               ext_aw_valid, ext_aw_ready;
  axi_pkg::addr_req_t ext_aw;
  logic               ext_w_valid, ext_w_ready;
  axi_pkg::w_t        ext_w;
  logic               ext_b_valid, ext_b_ready;
  axi_pkg::b_t        ext_b;

  integer      seed = 32'h606749af;
  // slave memory and scoreboard copy where unwritten words read as the fill pattern
  logic [31:0] ext_mem [logic [31:0]];
  logic [31:0] ref_mem [logic [31:0]];
  int          ext_ar_count = 0;
  int          ext_aw_count = 0;
  logic [3:0]  last_arid = '0;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  string       test_name = "";

  tb_clock u_clk (
    .clock(clock),
    .reset(reset)
  );

  mem_fabric_top u_dut (.*);

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'ha5c3_0f1e;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] ext_word(input logic [31:0] addr);
    return ext_mem.exists(addr) ? ext_mem[addr] : fill_word(addr);
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
  endfunction

  function automatic logic is_clint(input logic [31:0] addr);
    return addr >= soc_pkg::CLINT_BASE && addr < soc_pkg::CLINT_BASE + soc_pkg::CLINT_SPAN;
  endfunction

  function automatic logic coin();
    return 1'($random(seed));
  endfunction

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // small window so writes and reads overlap
  function automatic logic [31:0] ext_addr();
    return 32'h8000_0000 + 32'(pick(16)) * 32'd4;
  endfunction

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
      note_error();
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errors);
    end
  endtask

  task automatic check_idle();
    assert (!(fetch_ar_ready | lsu_ar_ready | fetch_r_valid | lsu_r_valid | lsu_b_valid |
              lsu_aw_ready | lsu_w_ready | ext_ar_valid | ext_aw_valid | ext_w_valid |
              ext_r_ready | ext_b_ready))
    else begin
      $display("a valid output was high during or just after reset");
      note_error();
    end
  endtask

  task automatic read_word(input logic is_lsu, input logic [31:0] addr, input logic stall,
                           output axi_pkg::r_t resp);
    axi_pkg::addr_req_t req;
    logic               done;
    logic               rdy;
    // junk id, len, size and burst that the arbiter must overwrite
    req = '{addr: addr, id: 4'hf, len: 8'd7, size: 3'd0, burst: 2'd2};
    if (is_lsu) begin
      lsu_ar_valid <= 1'b1;
      lsu_ar       <= req;
    end else begin
      fetch_ar_valid <= 1'b1;
      fetch_ar       <= req;
    end
    done = 1'b0;
    while (!done) begin
      @(posedge clock);
      done = is_lsu ? lsu_ar_ready : fetch_ar_ready;
    end
    if (is_lsu) begin
      lsu_ar_valid <= 1'b0;
    end else begin
      fetch_ar_valid <= 1'b0;
    end
    done = 1'b0;
    while (!done) begin
      rdy = stall ? coin() : 1'b1;
      if (is_lsu) begin
        lsu_r_ready <= rdy;
      end else begin
        fetch_r_ready <= rdy;
      end
      @(posedge clock);
      done = is_lsu ? (lsu_r_valid & lsu_r_ready) : (fetch_r_valid & fetch_r_ready);
      resp = is_lsu ? lsu_r : fetch_r;
    end
    if (is_lsu) begin
      lsu_r_ready <= 1'b0;
    end else begin
      fetch_r_ready <= 1'b0;
    end
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output axi_pkg::b_t resp);
    logic done;
    lsu_aw_valid <= 1'b1;
    lsu_aw       <= '{addr: addr, id: 4'd0, len: 8'd0, size: axi_pkg::SIZE_WORD,
                      burst: axi_pkg::BURST_INCR};
    lsu_w_valid  <= 1'b1;
    lsu_w        <= '{data: data, strb: strb, last: 1'b1};
    done = 1'b0;
    while (!done) begin
      @(posedge clock);
      done = lsu_aw_ready;
    end
    lsu_aw_valid <= 1'b0;
    lsu_w_valid  <= 1'b0;
    done = 1'b0;
    while (!done) begin
      lsu_b_ready <= coin();
      @(posedge clock);
      done = lsu_b_valid & lsu_b_ready;
      resp = lsu_b;
    end
    lsu_b_ready <= 1'b0;
  endtask

  // external slave read side
  initial begin : ext_read_slave
    axi_pkg::addr_req_t req;
    ext_ar_ready = 1'b0;
    ext_r_valid  = 1'b0;
    ext_r        = '0;
    wait (reset == 1'b0);
    @(posedge clock);
    forever begin
      ext_ar_ready <= coin();
      @(posedge clock);
      if (ext_ar_valid && ext_ar_ready) begin
        req = ext_ar;
        ext_ar_count++;
        last_arid = req.id;
        assert (!is_clint(req.addr)) else begin
          $display("timer address %h reached the external read channel", req.addr);
          note_error();
        end
        // single word beat on every external read
        check_value("arlen", 32'd0, 32'(req.len));
        check_value("arsize", 32'(axi_pkg::SIZE_WORD), 32'(req.size));
        check_value("arburst", 32'(axi_pkg::BURST_INCR), 32'(req.burst));
        ext_ar_ready <= 1'b0;
        repeat (pick(4)) @(posedge clock);
        ext_r_valid <= 1'b1;
        ext_r       <= '{data: ext_word(req.addr), resp: axi_pkg::RESP_OKAY, id: req.id,
                         last: 1'b1};
        @(posedge clock);
        while (!ext_r_ready) @(posedge clock);
        ext_r_valid <= 1'b0;
      end
    end
  end

  // external slave write side with aw and w taken independently
  initial begin : ext_write_slave
    axi_pkg::addr_req_t req;
    axi_pkg::w_t        beat;
    logic               got_aw;
    logic               got_w;
    ext_aw_ready = 1'b0;
    ext_w_ready  = 1'b0;
    ext_b_valid  = 1'b0;
    ext_b        = '0;
    wait (reset == 1'b0);
    @(posedge clock);
    forever begin
      got_aw = 1'b0;
      got_w  = 1'b0;
      while (!(got_aw && got_w)) begin
        ext_aw_ready <= ~got_aw & coin();
        ext_w_ready  <= ~got_w & coin();
        @(posedge clock);
        if (ext_aw_valid && ext_aw_ready) begin
          req    = ext_aw;
          got_aw = 1'b1;
        end
        if (ext_w_valid && ext_w_ready) begin
          beat  = ext_w;
          got_w = 1'b1;
        end
      end
      ext_aw_ready <= 1'b0;
      ext_w_ready  <= 1'b0;
      ext_aw_count++;
      assert (!is_clint(req.addr)) else begin
        $display("timer address %h reached the external write channel", req.addr);
        note_error();
      end
      ext_mem[req.addr] = merge_bytes(ext_word(req.addr), beat.data, beat.strb);
      repeat (pick(4)) @(posedge clock);
      ext_b_valid <= 1'b1;
      ext_b       <= '{resp: axi_pkg::RESP_OKAY, id: req.id};
      @(posedge clock);
      while (!ext_b_ready) @(posedge clock);
      ext_b_valid <= 1'b0;
    end
  end

  initial begin : watchdog
    #((10 + N_TXN * WORST_CYCLES) * CLK_NS);
    $display("timeout: the tests did not finish within %0d cycles",
             10 + N_TXN * WORST_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  initial begin : main
    axi_pkg::r_t r_fetch;
    axi_pkg::r_t r_lsu;
    axi_pkg::b_t b_resp;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] prev_time;
    int          ar_before;
    int          aw_before;

    {fetch_ar_valid, fetch_r_ready, lsu_ar_valid, lsu_r_ready} = '0;
    {lsu_aw_valid, lsu_w_valid, lsu_b_ready} = '0;
    fetch_ar = '0;
    lsu_ar   = '0;
    lsu_aw   = '0;
    lsu_w    = '0;

    begin_test("reset");
    @(posedge clock);
    while (reset) begin
      @(posedge clock);
      check_idle();
    end
    repeat (2) begin
      @(posedge clock);
      check_idle();
    end
    end_test();

    begin_test("ext_fetch_read");
    repeat (N_EXT_READS) begin
      addr_a = ext_addr();
      read_word(1'b0, addr_a, 1'b0, r_fetch);
      check_value("data", ref_word(addr_a), r_fetch.data);
      check_value("resp", 32'(axi_pkg::RESP_OKAY), 32'(r_fetch.resp));
      check_value("arid", 32'(soc_pkg::FETCH_ID), 32'(last_arid));
    end
    end_test();

    begin_test("lsu_write_read");
    repeat (N_WRITES) begin
      addr_a = ext_addr();
      wdata  = $random(seed);
      wstrb  = 4'(pick(16));
      write_word(addr_a, wdata, wstrb, b_resp);
      ref_mem[addr_a] = merge_bytes(ref_word(addr_a), wdata, wstrb);
      check_value("bresp", 32'(axi_pkg::RESP_OKAY), 32'(b_resp.resp));
      read_word(1'b1, addr_a, 1'b0, r_lsu);
      check_value("data", ref_word(addr_a), r_lsu.data);
    end
    end_test();

    begin_test("concurrent_reads");
    repeat (N_PAIRS) begin
      addr_a = ext_addr();
      addr_b = ext_addr();
      fork
        read_word(1'b0, addr_a, 1'b1, r_fetch);
        read_word(1'b1, addr_b, 1'b1, r_lsu);
      join
      check_value("fetch data", ref_word(addr_a), r_fetch.data);
      check_value("lsu data", ref_word(addr_b), r_lsu.data);
      check_value("fetch id", 32'(soc_pkg::FETCH_ID), 32'(r_fetch.id));
      check_value("lsu id", 32'(soc_pkg::LSU_ID), 32'(r_lsu.id));
    end
    end_test();

    begin_test("timer");
    ar_before = ext_ar_count;
    aw_before = ext_aw_count;
    prev_time = '0;
    repeat (N_TIMER) begin
      read_word(1'b1, soc_pkg::CLINT_BASE + soc_pkg::MTIME_LO_OFS, 1'b1, r_lsu);
      assert (r_lsu.data > prev_time) else begin
        $display("mtime low word did not increase: %h after %h", r_lsu.data, prev_time);
        note_error();
      end
      prev_time = r_lsu.data;
    end
    read_word(1'b0, soc_pkg::CLINT_BASE + soc_pkg::MTIME_HI_OFS, 1'b0, r_fetch);
    check_value("mtime hi", 32'd0, r_fetch.data);
    write_word(soc_pkg::CLINT_BASE + soc_pkg::MTIME_LO_OFS, 32'hffff_ffff, 4'hf, b_resp);
    check_value("bresp", 32'(axi_pkg::RESP_SLVERR), 32'(b_resp.resp));
    // the write must leave mtime counting from where it was
    read_word(1'b1, soc_pkg::CLINT_BASE + soc_pkg::MTIME_LO_OFS, 1'b0, r_lsu);
    assert (r_lsu.data > prev_time && r_lsu.data < prev_time + 32'd1000) else begin
      $display("mtime low word jumped after a timer write: %h after %h",
               r_lsu.data, prev_time);
      note_error();
    end
    assert (ext_ar_count == ar_before && ext_aw_count == aw_before) else begin
      $display("a timer access appeared on the external channels");
      note_error();
    end
    end_test();

    $display("tests: %0d passed, %0d failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== project.f ====
hdl/axi_pkg.sv
hdl/soc_pkg.sv
hdl/chan_slice.sv
hdl/read_arbiter.sv
hdl/addr_router.sv
hdl/clint_timer.sv
hdl/mem_fabric_top.sv
verif/tb_clock.sv
verif/fabric_chk.sv
verif/fabric_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the fabric testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fabric_tb \
  -f project.f -o fabric_sim \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/fabric_sim > sim.log 2>&1
cat sim.log
grep -q -F '** FAIL **' sim.log && { echo "simulation failed"; exit 1; }
grep -q -F '** PASS **' sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
